//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_mf2
FILELIST  := src.f

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- dv/mf2_chk.sv
// Concurrent assertions on the Multiface Two control FSM and their bind
`default_nettype none

module mf2_chk import mf2_pkg::*; (
	input wire              clk_sys,
	input wire              reset,
	input wire              nmi,
	input wire              paged,
	input wire mf2_config_t mf2_config
);

	// The NMI is released as the interface pages in
	nmi_release_pages_in: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) |-> paged)
		else $error("nmi fell without the interface paging in");

	nmi_rise_enabled: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi) |-> (mf2_config != CFG_DISABLED))
		else $error("nmi rose while the interface is disabled");

	paged_low_after_reset: assert property (@(posedge clk_sys)
		reset |=> !paged)
		else $error("paged is high in the cycle after reset");

endmodule

bind mf2_control mf2_chk i_chk (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.nmi        (nmi),
	.paged      (paged),
	.mf2_config (mf2_config)
);

`default_nettype wire

//--- dv/mf2_testdata.txt
# opcode addr data cfg expected, all values hex
# cfg is used by reset only, expected by mem_rd and chk_* only
key 0000 00 0 00
chk_nmi 0000 00 0 01
fetch 0066 00 0 00
chk_paged 0000 00 0 01
chk_nmi 0000 00 0 00
chk_rom 0100 00 0 01
mem_wr 2345 a5 0 00
mem_rd 2345 00 0 a5
mem_rd 4000 00 0 ff
io_wr 7f00 03 0 00
io_wr 7f00 54 0 00
mem_rd 3f93 00 0 54
mem_rd 3fcf 00 0 03
io_wr bc00 06 0 00
io_wr bd00 1e 0 00
mem_rd 3db6 00 0 1e
io_wr feea 00 0 00
chk_paged 0000 00 0 00
mem_rd 2345 00 0 ff
chk_rom 0100 00 0 00
io_wr fee8 00 0 00
chk_paged 0000 00 0 01
fetch 0065 00 0 00
io_wr feea 00 0 00
io_wr fee8 00 0 00
chk_paged 0000 00 0 00
reset 0000 00 2 00
key 0000 00 0 00
chk_nmi 0000 00 0 00
io_wr fee8 00 0 00
chk_paged 0000 00 0 00
reset 0000 00 1 00
io_wr fee8 00 0 00
chk_paged 0000 00 0 00
key 0000 00 0 00
fetch 0066 00 0 00
chk_paged 0000 00 0 01

//--- dv/tb_mf2.sv
// Testbench for the Multiface Two top level, driven from a testdata file
`default_nettype none

module tb_mf2 import mf2_pkg::*; ();

	localparam int CLK_HALF = 20;

	logic        clk_sys;
	logic        reset;
	logic [15:0] cpu_addr;
	logic  [7:0] cpu_dout;
	logic        m1;
	logic        io_wr;
	logic        mem_wr;
	logic        mem_rd;
	logic        key_nmi;
	mf2_config_t mf2_config;
	wire         nmi;
	wire         paged;
	wire         rom_en;
	wire   [7:0] dout;

	string       op_q[$];
	logic [15:0] addr_q[$];
	logic  [7:0] data_q[$];
	logic  [1:0] cfg_q[$];
	logic  [7:0] exp_q[$];
	int          value_errors;
	int          other_errors;
	int          cycles;
	int          cycle_limit;

	mf2_top i_dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.m1         (m1),
		.io_wr      (io_wr),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.key_nmi    (key_nmi),
		.mf2_config (mf2_config),
		.nmi        (nmi),
		.paged      (paged),
		.rom_en     (rom_en),
		.dout       (dout)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_value(input string name, input logic [7:0] expected,
			input logic [7:0] actual);
		if (actual !== expected) begin
			value_errors++;
			$display("[FAIL] %s expected %02h actual %02h", name, expected, actual);
		end
	endtask

	task automatic apply_reset(input logic [1:0] cfg);
		mf2_config = mf2_config_t'(cfg);
		reset = 1'b1;
		repeat (8) next_cycle();
		reset = 1'b0;
	endtask

	// Raise or drop the strobe that belongs to an opcode
	task automatic set_strobe(input string op, input logic level);
		case (op)
			"io_wr":  io_wr = level;
			"mem_wr": mem_wr = level;
			"fetch":  m1 = level;
			default:  key_nmi = level;
		endcase
	endtask

	task automatic load_testdata();
		int          fd;
		int          n;
		string       tok;
		string       rest;
		logic [15:0] a;
		logic  [7:0] d;
		logic  [1:0] c;
		logic  [7:0] e;
		fd = $fopen("dv/mf2_testdata.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("Could not open dv/mf2_testdata.txt");
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n != 1)
				break;
			if (tok.substr(0, 0) == "#") begin
				n = $fgets(rest, fd);
			end else begin
				n = $fscanf(fd, "%h %h %h %h", a, d, c, e);
				if (n != 4) begin
					other_errors++;
					$display("Malformed testdata line after opcode %s", tok);
				end
				op_q.push_back(tok);
				addr_q.push_back(a);
				data_q.push_back(d);
				cfg_q.push_back(c);
				exp_q.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////

	initial begin
		string name;
		reset = 1'b1;
		cpu_addr = '0;
		cpu_dout = '0;
		m1 = 1'b0;
		io_wr = 1'b0;
		mem_wr = 1'b0;
		mem_rd = 1'b0;
		key_nmi = 1'b0;
		mf2_config = CFG_ENABLED;
		value_errors = 0;
		other_errors = 0;
		cycle_limit = 0;
		load_testdata();
		cycle_limit = 40 * op_q.size() + 200;
		apply_reset(2'd0);
		foreach (op_q[i]) begin
			name = $sformatf("test %0d %0s", i + 1, op_q[i]);
			cpu_addr = addr_q[i];
			cpu_dout = data_q[i];
			case (op_q[i])
				"reset": apply_reset(cfg_q[i]);
				"io_wr", "mem_wr", "fetch", "key": begin
					set_strobe(op_q[i], 1'b1);
					next_cycle();
					// Quiet cycle so the next strobe is a fresh edge
					set_strobe(op_q[i], 1'b0);
					next_cycle();
				end
				"mem_rd": begin
					mem_rd = 1'b1;
					repeat (2) next_cycle();
					check_value(name, exp_q[i], dout);
					mem_rd = 1'b0;
				end
				"chk_nmi": begin
					next_cycle();
					check_value(name, exp_q[i], {7'd0, nmi});
				end
				"chk_paged": begin
					next_cycle();
					check_value(name, exp_q[i], {7'd0, paged});
				end
				"chk_rom": begin
					next_cycle();
					check_value(name, exp_q[i], {7'd0, rom_en});
				end
				default: begin
					other_errors++;
					$display("Unknown opcode %s in %s", op_q[i], name);
				end
			endcase
		end
		$display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Run limit from the number of testdata operations
	always @(posedge clk_sys) begin
		cycles++;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			other_errors++;
			$display("Timeout after %0d cycles, the run did not finish", cycles);
			$display("Errors: %0d value mismatches, %0d other", value_errors, other_errors);
			$display("Regression failed");
			$finish;
		end
	end

	initial cycles = 0;

endmodule

`default_nettype wire

//--- src.f
verilog/mf2_pkg.sv
verilog/mf2_control.sv
verilog/mf2_store_decode.sv
verilog/mf2_ram.sv
verilog/mf2_top.sv
dv/mf2_chk.sv
dv/tb_mf2.sv

//--- verilog/mf2_control.sv
// Multiface Two paging and NMI state machine with hidden flag
`default_nettype none

module mf2_control import mf2_pkg::*; (
	input  wire              clk_sys,
	input  wire              reset,
	input  wire       [15:0] cpu_addr,
	input  wire              m1,
	input  wire              key_nmi,
	input  wire mf2_config_t mf2_config,
	input  wire              page_wr,
	input  wire              page_on,
	output logic             nmi,
	output logic             paged,
	output logic             rom_en
);

	mf2_state_t state;
	mf2_state_t state_next;
	logic       hidden;
	logic       key_nmi_d;
	logic       m1_d;
	logic       key_rise;
	logic       fetch_rise;
	logic       page_allow;

	assign key_rise   = key_nmi & ~key_nmi_d;
	assign fetch_rise = m1 & ~m1_d;
	// Page port only works when not hidden and not switched off
	assign page_allow = page_on & ~hidden & (mf2_config != CFG_DISABLED);

	//////////////////////////////////////////////////
	// Next state
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (key_rise && mf2_config != CFG_DISABLED)
					state_next = ST_NMI_PENDING;
			end
			ST_NMI_PENDING: begin
				// CPU has taken the NMI
				if (fetch_rise && cpu_addr == NMI_ENTRY_ADDR)
					state_next = ST_PAGED;
			end
			default: state_next = state;
		endcase

		// Port writes override the fetch path
		if (page_wr) begin
			if (page_allow)
				state_next = ST_PAGED;
			else if (state == ST_PAGED)
				state_next = ST_IDLE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state     <= ST_IDLE;
			hidden    <= (mf2_config == CFG_HIDDEN) || (mf2_config == CFG_DISABLED);
			key_nmi_d <= 1'b0;
			m1_d      <= 1'b0;
		end else begin
			state     <= state_next;
			key_nmi_d <= key_nmi;
			m1_d      <= m1;
			if (state == ST_NMI_PENDING && fetch_rise && cpu_addr == NMI_ENTRY_ADDR)
				hidden <= 1'b0;
			// Software asks to hide the interface
			if (state == ST_PAGED && fetch_rise && cpu_addr == HIDE_ADDR)
				hidden <= 1'b1;
		end
	end

	assign nmi    = (state == ST_NMI_PENDING);
	assign paged  = (state == ST_PAGED);
	assign rom_en = paged && (cpu_addr[15:13] == ROM_WINDOW);

endmodule

`default_nettype wire

//--- verilog/mf2_pkg.sv
// Multiface Two state and config enums, RAM size, port and shadow slot constants
`default_nettype none

package mf2_pkg;

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////

	// Interface state
	typedef enum logic [1:0] {
		ST_IDLE        = 2'd0,
		ST_NMI_PENDING = 2'd1,
		ST_PAGED       = 2'd2
	} mf2_state_t;

	// User setting from the OSD menu
	typedef enum logic [1:0] {
		CFG_ENABLED  = 2'd0,
		CFG_HIDDEN   = 2'd1,
		CFG_DISABLED = 2'd2
	} mf2_config_t;

	//////////////////////////////////////////////////
	// Addresses
	//////////////////////////////////////////////////

	localparam int MF2_RAM_AW = 13;

	// Opcode fetch addresses seen on M1
	localparam logic [15:0] NMI_ENTRY_ADDR = 16'h0066;
	localparam logic [15:0] HIDE_ADDR      = 16'h0065;

	// FEE8/FEEA, bit 1 selects in or out
	localparam logic [13:0] PAGE_PORT_BASE = 14'h3FBA;

	// Compared with cpu_addr[15:13]
	localparam logic [2:0] ROM_WINDOW = 3'b000;
	localparam logic [2:0] RAM_WINDOW = 3'b001;

	// I/O port high bytes of the shadowed chips
	localparam logic [7:0] GA_PORT_HI   = 8'h7F;
	localparam logic [7:0] CRTC_SEL_HI  = 8'hBC;
	localparam logic [7:0] CRTC_DATA_HI = 8'hBD;
	localparam logic [7:0] PPI_PORT_HI  = 8'hF7;
	localparam logic [7:0] ROM_SEL_HI   = 8'hDF;

	// Where the shadowed registers sit in the 8 KB RAM
	localparam logic [12:0] SLOT_PEN       = 13'h1FCF;
	localparam logic [12:0] SLOT_BORDER    = 13'h1FDF;
	localparam logic [12:0] SLOT_PEN_BASE  = 13'h1F90;
	localparam logic [12:0] SLOT_MODE      = 13'h1FEF;
	localparam logic [12:0] SLOT_BANK      = 13'h1FFF;
	localparam logic [12:0] SLOT_CRTC_SEL  = 13'h1CFF;
	localparam logic [12:0] SLOT_CRTC_BASE = 13'h1DB0;
	localparam logic [12:0] SLOT_PPI       = 13'h17FF;
	localparam logic [12:0] SLOT_ROM       = 13'h1AAC;

endpackage

`default_nettype wire

//--- verilog/mf2_ram.sv
// Multiface Two 8 KB shadow RAM with registered port and read data gating
`default_nettype none

module mf2_ram import mf2_pkg::*; (
	input  wire                   clk_sys,
	input  wire            [15:0] cpu_addr,
	input  wire             [7:0] cpu_dout,
	input  wire                   mem_wr,
	input  wire                   mem_rd,
	input  wire                   paged,
	input  wire                   store_wr,
	input  wire  [MF2_RAM_AW-1:0] store_addr,
	input  wire             [7:0] store_data,
	output logic            [7:0] dout
);

	logic            [7:0] mem [0:(1 << MF2_RAM_AW) - 1];
	logic [MF2_RAM_AW-1:0] ram_a;
	logic            [7:0] ram_in;
	logic            [7:0] ram_out;
	logic                  ram_we;
	logic                  cpu_sel;

	assign cpu_sel = paged && (cpu_addr[15:13] == RAM_WINDOW);

	// Register shadow stores win over CPU writes
	always_ff @(posedge clk_sys) begin
		if (store_wr) begin
			ram_a  <= store_addr;
			ram_in <= store_data;
			ram_we <= 1'b1;
		end else if (mem_wr && cpu_sel) begin
			ram_a  <= cpu_addr[MF2_RAM_AW-1:0];
			ram_in <= cpu_dout;
			ram_we <= 1'b1;
		end else begin
			ram_a  <= cpu_addr[MF2_RAM_AW-1:0];
			ram_we <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= mem[ram_a];
		end
	end

	// Open bus reads as FF
	assign dout = (cpu_sel && mem_rd) ? ram_out : 8'hFF;

endmodule

`default_nettype wire

//--- verilog/mf2_store_decode.sv
// I/O write edge detect, page port and shadow slot decode, pen and CRTC index latches
`default_nettype none

module mf2_store_decode import mf2_pkg::*; (
	input  wire                   clk_sys,
	input  wire                   reset,
	input  wire            [15:0] cpu_addr,
	input  wire             [7:0] cpu_dout,
	input  wire                   io_wr,
	output logic                  page_wr,
	output logic                  page_on,
	output logic                  store_wr,
	output logic [MF2_RAM_AW-1:0] store_addr,
	output logic            [7:0] store_data
);

	logic                  io_wr_d;
	logic                  io_wr_rise;
	logic                  page_hit;
	logic            [4:0] pen_index;
	logic            [3:0] crtc_reg;
	logic [MF2_RAM_AW-1:0] slot_addr;

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_wr_d <= 1'b0;
		else
			io_wr_d <= io_wr;
	end

	assign io_wr_rise = io_wr & ~io_wr_d;
	assign page_hit   = (cpu_addr[15:2] == PAGE_PORT_BASE);

	// FEE8 pages in, FEEA pages out
	assign page_wr = io_wr_rise & page_hit;
	assign page_on = ~cpu_addr[1];

	//////////////////////////////////////////////////
	// Shadow slot decode
	//////////////////////////////////////////////////

	always_comb begin
		slot_addr = '0;
		case (cpu_addr[15:8])
			GA_PORT_HI: begin
				// Gate array function in data bits 7:6
				case (cpu_dout[7:6])
					2'b00: slot_addr = SLOT_PEN;
					2'b01: begin
						if (pen_index[4])
							slot_addr = SLOT_BORDER;
						else
							slot_addr = SLOT_PEN_BASE + {9'd0, pen_index[3:0]};
					end
					2'b10: slot_addr = SLOT_MODE;
					default: slot_addr = SLOT_BANK;
				endcase
			end
			CRTC_SEL_HI:  slot_addr = SLOT_CRTC_SEL;
			CRTC_DATA_HI: slot_addr = SLOT_CRTC_BASE + {9'd0, crtc_reg};
			PPI_PORT_HI:  slot_addr = SLOT_PPI;
			ROM_SEL_HI:   slot_addr = SLOT_ROM;
			default:      slot_addr = '0;
		endcase
	end

	assign store_wr   = io_wr_rise & ~page_hit & (|slot_addr);
	assign store_addr = slot_addr;
	assign store_data = cpu_dout;

	// Selected pen and CRTC register for later data writes
	always_ff @(posedge clk_sys) begin
		if (store_wr) begin
			if (cpu_addr[15:8] == GA_PORT_HI && cpu_dout[7:6] == 2'b00)
				pen_index <= cpu_dout[4:0];
			if (cpu_addr[15:8] == CRTC_SEL_HI)
				crtc_reg <= cpu_dout[3:0];
		end
	end

endmodule

`default_nettype wire

//--- verilog/mf2_top.sv
// Multiface Two top level joining control, store decode and shadow RAM
`default_nettype none

module mf2_top import mf2_pkg::*; (
	input  wire              clk_sys,
	input  wire              reset,
	input  wire       [15:0] cpu_addr,
	input  wire        [7:0] cpu_dout,
	input  wire              m1,
	input  wire              io_wr,
	input  wire              mem_wr,
	input  wire              mem_rd,
	input  wire              key_nmi,
	input  wire mf2_config_t mf2_config,
	output logic             nmi,
	output logic             paged,
	output logic             rom_en,
	output logic       [7:0] dout
);

	logic                  page_wr;
	logic                  page_on;
	logic                  store_wr;
	logic [MF2_RAM_AW-1:0] store_addr;
	logic            [7:0] store_data;

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	mf2_control i_control (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.m1         (m1),
		.key_nmi    (key_nmi),
		.mf2_config (mf2_config),
		.page_wr    (page_wr),
		.page_on    (page_on),
		.nmi        (nmi),
		.paged      (paged),
		.rom_en     (rom_en)
	);

	mf2_store_decode i_store_decode (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.io_wr      (io_wr),
		.page_wr    (page_wr),
		.page_on    (page_on),
		.store_wr   (store_wr),
		.store_addr (store_addr),
		.store_data (store_data)
	);

	// Shadow RAM, readable only while paged
	mf2_ram i_ram (
		.clk_sys    (clk_sys),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.mem_wr     (mem_wr),
		.mem_rd     (mem_rd),
		.paged      (paged),
		.store_wr   (store_wr),
		.store_addr (store_addr),
		.store_data (store_data),
		.dout       (dout)
	);

endmodule

`default_nettype wire
